//--- hw/iface_pkg.sv
`default_nettype none

package iface_pkg;

    localparam int DATA_WIDTH     = 64;
    localparam int ADDR_WIDTH     = 20;  // word count and glb address.
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH) + 1;  // extra wrap bit.
    localparam int NUM_BANKS      = 3;

    typedef enum logic [1:0] {
        BANK_IFMAP  = 2'd0,
        BANK_FILTER = 2'd1,
        BANK_BIAS   = 2'd2
    } bank_e;

    // latched at start, read by the link side while busy.
    typedef struct packed {
        bank_e                 bank;
        logic [ADDR_WIDTH-1:0] words;
    } xfer_cmd_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } glb_wr_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } glb_rd_t;

endpackage

`default_nettype wire

//--- hw/cdc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module cdc_fifo import iface_pkg::*; (
    input  wire                   wr_clk,
    input  wire                   rd_clk,
    input  wire                   arst_n,
    input  wire                   push,
    input  wire  [DATA_WIDTH-1:0] wr_data,
    output logic                  full,
    input  wire                   pop,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  empty
);

    logic [DATA_WIDTH-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_bin;
    logic [FIFO_PTR_WIDTH-1:0] wr_gray;
    logic [FIFO_PTR_WIDTH-1:0] wr_bin_next;
    logic [FIFO_PTR_WIDTH-1:0] rd_bin;
    logic [FIFO_PTR_WIDTH-1:0] rd_gray;
    logic [FIFO_PTR_WIDTH-1:0] rd_bin_next;
    logic [FIFO_PTR_WIDTH-1:0] rd_gray_s1;  // read pointer in write domain.
    logic [FIFO_PTR_WIDTH-1:0] rd_gray_s2;
    logic [FIFO_PTR_WIDTH-1:0] wr_gray_s1;  // write pointer in read domain.
    logic [FIFO_PTR_WIDTH-1:0] wr_gray_s2;
    logic                      do_push;
    logic                      do_pop;

    assign do_push     = push && !full;
    assign do_pop      = pop && !empty;
    assign wr_bin_next = wr_bin + FIFO_PTR_WIDTH'(do_push);
    assign rd_bin_next = rd_bin + FIFO_PTR_WIDTH'(do_pop);

    always_ff @(posedge wr_clk) begin
        if (do_push) begin
            mem[wr_bin[FIFO_PTR_WIDTH-2:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // full when the pointers differ only in the two top gray bits.
    assign full = (wr_gray == {~rd_gray_s2[FIFO_PTR_WIDTH-1 -: 2],
                               rd_gray_s2[FIFO_PTR_WIDTH-3:0]});

    assign empty   = (rd_gray == wr_gray_s2);
    assign rd_data = mem[rd_bin[FIFO_PTR_WIDTH-2:0]];  // head word.

endmodule

`default_nettype wire

//--- hw/glb_bank_port.sv
`timescale 1ns/1ns
`default_nettype none

module glb_bank_port import iface_pkg::*; (
    input  wire                   core_clk,
    input  wire                   arst_n,
    input  wire                   clear,
    input  wire  [ADDR_WIDTH-1:0] words,
    input  wire                   word_strobe,
    input  wire  [DATA_WIDTH-1:0] word_data,
    output glb_wr_t               wr,
    output logic                  done
);

    logic [ADDR_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] addr_next;

    assign addr_next = addr + 1'b1;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= '0;
            wr   <= '0;
            done <= 1'b0;
        end else begin
            wr.en <= word_strobe;
            done  <= word_strobe && (addr_next == words);  // with the last write.
            if (word_strobe) begin
                wr.addr <= addr;
                wr.data <= word_data;
            end
            if (clear) begin
                addr <= '0;
            end else if (word_strobe) begin
                addr <= addr_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/link_dma.sv
`timescale 1ns/1ns
`default_nettype none

module link_dma import iface_pkg::*; (
    input  wire                   link_clk,
    input  wire                   arst_n,
    input  wire  xfer_cmd_t       cmd,
    input  wire                   fwd_go_tgl,
    input  wire                   bwd_go_tgl,
    output logic                  bwd_done_tgl,
    output logic                  dram_r_en,
    input  wire                   dram_valid,
    input  wire  [DATA_WIDTH-1:0] dram_rdata,
    output logic                  dram_w_en,
    output logic [DATA_WIDTH-1:0] dram_wdata,
    output logic                  fifo_push,
    output logic [DATA_WIDTH-1:0] fifo_wdata,
    input  wire                   fifo_full,
    output logic                  fifo_pop,
    input  wire  [DATA_WIDTH-1:0] fifo_rdata,
    input  wire                   fifo_empty
);

    typedef enum logic [1:0] {L_IDLE, L_FWD, L_BWD} state_e;

    state_e                state;
    logic [1:0]            rst_q;
    logic                  link_rst_n;
    logic [2:0]            fwd_q;
    logic [2:0]            bwd_q;
    logic                  fwd_go;
    logic                  bwd_go;
    logic                  pending;  // one dram read outstanding.
    logic [ADDR_WIDTH-1:0] cnt;
    logic [ADDR_WIDTH-1:0] cnt_next;
    logic                  fwd_active;
    logic                  issue;

    always_ff @(posedge link_clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_q <= 2'b00;
        end else begin
            rst_q <= {rst_q[0], 1'b1};
        end
    end

    assign link_rst_n = rst_q[1];

    always_ff @(posedge link_clk or negedge link_rst_n) begin
        if (!link_rst_n) begin
            fwd_q <= '0;
            bwd_q <= '0;
        end else begin
            fwd_q <= {fwd_q[1:0], fwd_go_tgl};
            bwd_q <= {bwd_q[1:0], bwd_go_tgl};
        end
    end

    assign fwd_go = fwd_q[2] ^ fwd_q[1];
    assign bwd_go = bwd_q[2] ^ bwd_q[1];

    // first read can leave in the same cycle the toggle is seen.
    assign fwd_active = (state == L_FWD) || ((state == L_IDLE) && fwd_go);
    assign issue      = fwd_active && !pending && (cnt != cmd.words) && !fifo_full;
    assign cnt_next   = cnt + 1'b1;

    assign fifo_push  = (state == L_FWD) && dram_valid;
    assign fifo_wdata = dram_rdata;
    assign fifo_pop   = (state == L_BWD) && !fifo_empty;

    always_ff @(posedge link_clk or negedge link_rst_n) begin
        if (!link_rst_n) begin
            state        <= L_IDLE;
            cnt          <= '0;
            pending      <= 1'b0;
            dram_r_en    <= 1'b0;
            dram_w_en    <= 1'b0;
            bwd_done_tgl <= 1'b0;
        end else begin
            dram_r_en <= issue;
            dram_w_en <= fifo_pop;
            if (issue) begin
                pending <= 1'b1;
                cnt     <= cnt_next;
            end
            case (state)
                L_IDLE: begin
                    if (fwd_go) begin
                        state <= L_FWD;
                    end else if (bwd_go) begin
                        state <= L_BWD;
                    end
                end
                L_FWD: begin
                    if (dram_valid) begin
                        pending <= 1'b0;
                        if (cnt == cmd.words) begin  // last word returned.
                            cnt   <= '0;
                            state <= L_IDLE;
                        end
                    end
                end
                L_BWD: begin
                    if (fifo_pop) begin
                        cnt <= cnt_next;
                        if (cnt_next == cmd.words) begin
                            cnt          <= '0;
                            bwd_done_tgl <= ~bwd_done_tgl;
                            state        <= L_IDLE;
                        end
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge link_clk) begin
        dram_wdata <= fifo_rdata;
    end

endmodule

`default_nettype wire

//--- hw/transfer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_ctrl import iface_pkg::*; (
    input  wire                   core_clk,
    input  wire                   arst_n,
    input  wire                   start_forward,
    input  wire                   start_backward,
    input  wire  bank_e           bank_sel,
    input  wire  [ADDR_WIDTH-1:0] words_num,
    output xfer_cmd_t             cmd,
    output logic                  fwd_go_tgl,
    output logic                  bwd_go_tgl,
    input  wire                   bwd_done_tgl,
    output logic                  fifo_pop,
    input  wire                   fifo_empty,
    input  wire  [DATA_WIDTH-1:0] fifo_rdata,
    output logic                  fifo_push,
    output logic [DATA_WIDTH-1:0] fifo_wdata,
    input  wire                   fifo_full,
    output glb_rd_t               glb_rd,
    input  wire  [DATA_WIDTH-1:0] glb_rdata,
    output logic [NUM_BANKS-1:0]  word_strobe,
    output logic [DATA_WIDTH-1:0] word_data,
    output logic                  bank_clear,
    input  wire  [NUM_BANKS-1:0]  bank_done,
    output logic                  transfer_done
);

    typedef enum logic [1:0] {C_IDLE, C_FWD, C_BWD} state_e;

    state_e                state;
    logic [1:0]            rst_q;
    logic                  core_rst_n;
    logic [2:0]            done_q;
    logic                  bwd_done;
    logic [ADDR_WIDTH-1:0] rd_cnt;
    logic                  rd_q;  // glb data returns this cycle.
    logic                  issue;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_q <= 2'b00;
        end else begin
            rst_q <= {rst_q[0], 1'b1};
        end
    end

    assign core_rst_n = rst_q[1];

    always_ff @(posedge core_clk or negedge core_rst_n) begin
        if (!core_rst_n) begin
            done_q <= '0;
        end else begin
            done_q <= {done_q[1:0], bwd_done_tgl};
        end
    end

    assign bwd_done = done_q[2] ^ done_q[1];

    assign fifo_pop  = (state == C_FWD) && !fifo_empty;
    assign word_data = fifo_rdata;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            word_strobe[b] = fifo_pop && (int'(cmd.bank) == b);
        end
    end

    // nothing in flight, so full is up to date and the read has room.
    assign issue = (state == C_BWD) && (rd_cnt != cmd.words) && !fifo_full
                   && !glb_rd.en && !rd_q;

    assign fifo_push  = rd_q;
    assign fifo_wdata = glb_rdata;

    always_ff @(posedge core_clk or negedge core_rst_n) begin
        if (!core_rst_n) begin
            state         <= C_IDLE;
            cmd           <= '0;
            fwd_go_tgl    <= 1'b0;
            bwd_go_tgl    <= 1'b0;
            bank_clear    <= 1'b0;
            transfer_done <= 1'b0;
            glb_rd        <= '0;
            rd_cnt        <= '0;
            rd_q          <= 1'b0;
        end else begin
            bank_clear    <= 1'b0;
            transfer_done <= 1'b0;
            rd_q          <= glb_rd.en;
            glb_rd.en     <= issue;
            if (issue) begin
                glb_rd.addr <= rd_cnt;
                rd_cnt      <= rd_cnt + 1'b1;
            end
            case (state)
                C_IDLE: begin
                    if (start_forward || start_backward) begin
                        cmd        <= '{bank: bank_sel, words: words_num};
                        bank_clear <= 1'b1;
                    end
                    if (start_forward) begin
                        fwd_go_tgl <= ~fwd_go_tgl;
                        state      <= C_FWD;
                    end else if (start_backward) begin
                        bwd_go_tgl <= ~bwd_go_tgl;
                        rd_cnt     <= '0;
                        state      <= C_BWD;
                    end
                end
                C_FWD: begin
                    if (bank_done[cmd.bank]) begin
                        transfer_done <= 1'b1;
                        state         <= C_IDLE;
                    end
                end
                C_BWD: begin
                    if (bwd_done) begin  // link side wrote the last word.
                        transfer_done <= 1'b1;
                        state         <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/interface_unit.sv
`timescale 1ns/1ns
`default_nettype none

module interface_unit import iface_pkg::*; (
    input  wire                           core_clk,
    input  wire                           link_clk,
    input  wire                           arst_n,
    input  wire                           start_forward,
    input  wire                           start_backward,
    input  wire  bank_e                   bank_sel,
    input  wire  [ADDR_WIDTH-1:0]         words_num,
    output glb_wr_t [NUM_BANKS-1:0]       glb_wr,
    output glb_rd_t                       glb_rd,
    input  wire  [DATA_WIDTH-1:0]         glb_rdata,
    output logic                          transfer_done,
    output logic                          dram_r_en,
    input  wire                           dram_valid,
    input  wire  [DATA_WIDTH-1:0]         dram_rdata,
    output logic                          dram_w_en,
    output logic [DATA_WIDTH-1:0]         dram_wdata
);

    xfer_cmd_t             cmd;
    logic                  fwd_go_tgl;
    logic                  bwd_go_tgl;
    logic                  bwd_done_tgl;
    logic                  fwd_push;
    logic [DATA_WIDTH-1:0] fwd_wdata;
    logic                  fwd_full;
    logic                  fwd_pop;
    logic [DATA_WIDTH-1:0] fwd_rdata;
    logic                  fwd_empty;
    logic                  bwd_push;
    logic [DATA_WIDTH-1:0] bwd_wdata;
    logic                  bwd_full;
    logic                  bwd_pop;
    logic [DATA_WIDTH-1:0] bwd_rdata;
    logic                  bwd_empty;
    logic [NUM_BANKS-1:0]  word_strobe;
    logic [DATA_WIDTH-1:0] word_data;
    logic                  bank_clear;
    logic [NUM_BANKS-1:0]  bank_done;

    // dram to glb.
    cdc_fifo fwd_fifo (
        .wr_clk  (link_clk),
        .rd_clk  (core_clk),
        .arst_n  (arst_n),
        .push    (fwd_push),
        .wr_data (fwd_wdata),
        .full    (fwd_full),
        .pop     (fwd_pop),
        .rd_data (fwd_rdata),
        .empty   (fwd_empty)
    );

    // glb to dram.
    cdc_fifo bwd_fifo (
        .wr_clk  (core_clk),
        .rd_clk  (link_clk),
        .arst_n  (arst_n),
        .push    (bwd_push),
        .wr_data (bwd_wdata),
        .full    (bwd_full),
        .pop     (bwd_pop),
        .rd_data (bwd_rdata),
        .empty   (bwd_empty)
    );

    link_dma link_dma_i (
        .link_clk     (link_clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .fwd_go_tgl   (fwd_go_tgl),
        .bwd_go_tgl   (bwd_go_tgl),
        .bwd_done_tgl (bwd_done_tgl),
        .dram_r_en    (dram_r_en),
        .dram_valid   (dram_valid),
        .dram_rdata   (dram_rdata),
        .dram_w_en    (dram_w_en),
        .dram_wdata   (dram_wdata),
        .fifo_push    (fwd_push),
        .fifo_wdata   (fwd_wdata),
        .fifo_full    (fwd_full),
        .fifo_pop     (bwd_pop),
        .fifo_rdata   (bwd_rdata),
        .fifo_empty   (bwd_empty)
    );

    transfer_ctrl transfer_ctrl_i (
        .core_clk       (core_clk),
        .arst_n         (arst_n),
        .start_forward  (start_forward),
        .start_backward (start_backward),
        .bank_sel       (bank_sel),
        .words_num      (words_num),
        .cmd            (cmd),
        .fwd_go_tgl     (fwd_go_tgl),
        .bwd_go_tgl     (bwd_go_tgl),
        .bwd_done_tgl   (bwd_done_tgl),
        .fifo_pop       (fwd_pop),
        .fifo_empty     (fwd_empty),
        .fifo_rdata     (fwd_rdata),
        .fifo_push      (bwd_push),
        .fifo_wdata     (bwd_wdata),
        .fifo_full      (bwd_full),
        .glb_rd         (glb_rd),
        .glb_rdata      (glb_rdata),
        .word_strobe    (word_strobe),
        .word_data      (word_data),
        .bank_clear     (bank_clear),
        .bank_done      (bank_done),
        .transfer_done  (transfer_done)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        glb_bank_port bank_port_i (
            .core_clk    (core_clk),
            .arst_n      (arst_n),
            .clear       (bank_clear),
            .words       (cmd.words),
            .word_strobe (word_strobe[b]),
            .word_data   (word_data),
            .wr          (glb_wr[b]),
            .done        (bank_done[b])
        );
    end

endmodule

`default_nettype wire

//--- tests/interface_checker.sv
`timescale 1ns/1ns
`default_nettype none

module interface_checker import iface_pkg::*; (
    input wire                          core_clk,
    input wire                          link_clk,
    input wire                          arst_n,
    input wire glb_wr_t [NUM_BANKS-1:0] glb_wr,
    input wire glb_rd_t                 glb_rd,
    input wire                          transfer_done,
    input wire                          dram_r_en,
    input wire                          dram_w_en,
    input wire [DATA_WIDTH-1:0]         dram_wdata
);

    logic [DATA_WIDTH-1:0] glb_exp [$];  // dram words in arrival order.
    logic [DATA_WIDTH-1:0] dram_exp [$];
    logic                  busy = 1'b0;
    logic                  backward = 1'b0;
    bank_e                 bank = BANK_IFMAP;
    int                    words = 0;
    int                    glb_writes = 0;
    int                    glb_reads = 0;
    int                    dram_reads = 0;
    int                    dram_writes = 0;
    int                    dones = 0;
    int                    tests = 0;
    int                    failed = 0;
    int                    errors = 0;
    int                    errors_before = 0;

    task automatic report(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic begin_transfer(input logic bwd, input bank_e sel, input int n);
        busy          = 1'b1;
        backward      = bwd;
        bank          = sel;
        words         = n;
        glb_writes    = 0;
        glb_reads     = 0;
        dram_reads    = 0;
        dram_writes   = 0;
        dones         = 0;
        errors_before = errors;
        glb_exp.delete();
        dram_exp.delete();
    endtask

    task automatic expect_glb_write(input logic [DATA_WIDTH-1:0] word);
        glb_exp.push_back(word);
    endtask

    task automatic expect_dram_write(input logic [DATA_WIDTH-1:0] word);
        dram_exp.push_back(word);
    endtask

    task automatic end_transfer();
        if (backward && dram_writes != words) begin
            report($sformatf("%0d dram writes for %0d words", dram_writes, words));
        end
        if (backward && glb_reads != words) begin
            report($sformatf("%0d glb reads for %0d words", glb_reads, words));
        end
        if (!backward && glb_writes != words) begin
            report($sformatf("%0d glb writes for %0d words", glb_writes, words));
        end
        if (!backward && dram_reads != words) begin
            report($sformatf("%0d dram reads for %0d words", dram_reads, words));
        end
        if (dones != 1) begin
            report($sformatf("%0d transfer_done pulses instead of one", dones));
        end
        tests++;
        if (errors != errors_before) begin
            failed++;
        end
        $display("test %0d: %s %s, %0d words, %s", tests, backward ? "backward" : "forward",
                 bank.name(), words, (errors == errors_before) ? "ok" : "failed");
        busy = 1'b0;
    endtask

    always @(posedge core_clk) begin
        if (arst_n === 1'b1) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (glb_wr[b].en !== 1'b0) begin
                    if (!busy || backward || int'(bank) != b) begin
                        report($sformatf("glb write on bank %0d outside a forward transfer to it",
                                         b));
                    end else if (glb_exp.size() == 0) begin
                        report("glb write with no dram word left to match");
                    end else begin
                        check_value($sformatf("glb_wr[%0d].addr", b), DATA_WIDTH'(glb_writes),
                                    DATA_WIDTH'(glb_wr[b].addr));
                        check_value($sformatf("glb_wr[%0d].data", b), glb_exp.pop_front(),
                                    glb_wr[b].data);
                        glb_writes++;
                    end
                end
            end
            if (glb_rd.en !== 1'b0) begin
                if (!(busy && backward)) begin
                    report("glb read outside a backward transfer");
                end else begin
                    check_value("glb_rd.addr", DATA_WIDTH'(glb_reads),
                                DATA_WIDTH'(glb_rd.addr));
                    glb_reads++;
                end
            end
            if (transfer_done !== 1'b0) begin
                if (!busy) begin
                    report("transfer_done while no transfer runs");
                end else begin
                    dones++;
                    if ((backward ? dram_writes : glb_writes) != words) begin
                        report("transfer_done came before the last word");
                    end
                end
            end
        end
    end

    always @(posedge link_clk) begin
        if (arst_n === 1'b1) begin
            if (dram_r_en !== 1'b0) begin
                if (!busy || backward) begin
                    report("dram read outside a forward transfer");
                end else begin
                    dram_reads++;
                end
            end
            if (dram_w_en !== 1'b0) begin
                if (!busy || !backward) begin
                    report("dram write outside a backward transfer");
                end else if (dram_exp.size() == 0) begin
                    report("dram write with no glb word left to match");
                end else begin
                    check_value("dram_wdata", dram_exp.pop_front(), dram_wdata);
                    dram_writes++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_interface_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_interface_unit import iface_pkg::*; ();

    localparam int    CORE_PERIOD = 100;
    localparam int    LINK_PERIOD = 140;
    localparam int    SEED        = 41994;
    localparam string VECTOR_FILE = "tests/interface_vectors.txt";
    localparam int    GLB_WORDS   = 64;
    localparam int    MAX_TESTS   = 64;

    logic                  core_clk = 1'b0;
    logic                  link_clk = 1'b0;
    logic                  arst_n;
    logic                  start_forward;
    logic                  start_backward;
    bank_e                 bank_sel;
    logic [ADDR_WIDTH-1:0] words_num;
    glb_wr_t [NUM_BANKS-1:0] glb_wr;
    glb_rd_t               glb_rd;
    logic [DATA_WIDTH-1:0] glb_rdata = '0;
    logic                  transfer_done;
    logic                  dram_r_en;
    logic                  dram_valid = 1'b0;
    logic [DATA_WIDTH-1:0] dram_rdata = '0;
    logic                  dram_w_en;
    logic [DATA_WIDTH-1:0] dram_wdata;

    integer                seed;
    logic [DATA_WIDTH-1:0] glb_mem [GLB_WORDS];
    logic [ADDR_WIDTH-1:0] rd_addr;
    int                    vec_dir [MAX_TESTS];
    logic [1:0]            vec_bank [MAX_TESTS];
    int                    vec_words [MAX_TESTS];
    int                    num_tests = 0;
    longint                limit_ns = 0;
    logic                  limit_ready = 1'b0;

    always #(CORE_PERIOD / 2) core_clk = ~core_clk;
    always #(LINK_PERIOD / 2) link_clk = ~link_clk;

    interface_unit interface_unit_i (.*);

    interface_checker checker_i (
        .core_clk      (core_clk),
        .link_clk      (link_clk),
        .arst_n        (arst_n),
        .glb_wr        (glb_wr),
        .glb_rd        (glb_rd),
        .transfer_done (transfer_done),
        .dram_r_en     (dram_r_en),
        .dram_w_en     (dram_w_en),
        .dram_wdata    (dram_wdata)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $finish;
    endtask

    task automatic read_vectors();
        int    fd;
        int    d;
        int    b;
        int    n;
        string line;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %d %d", d, b, n) == 3 && num_tests < MAX_TESTS) begin
                    vec_dir[num_tests]   = d;
                    vec_bank[num_tests]  = b[1:0];
                    vec_words[num_tests] = n;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one start pulse, a stray start while busy, then wait for done.
    task automatic run_transfer(input int t);
        logic backward;
        logic seen;
        int   cycles;
        backward = (vec_dir[t] != 0);
        checker_i.begin_transfer(backward, bank_e'(vec_bank[t]), vec_words[t]);
        for (int i = 0; i < vec_words[t]; i++) begin
            if (backward) begin
                checker_i.expect_dram_write(glb_mem[i]);
            end
        end
        bank_sel       = bank_e'(vec_bank[t]);
        words_num      = vec_words[t][ADDR_WIDTH-1:0];
        start_forward  = !backward;
        start_backward = backward;
        cycles         = 0;
        seen           = 1'b0;
        while (!seen) begin
            @(posedge core_clk);
            seen = (transfer_done === 1'b1);
            #5;
            start_forward  = 1'b0;
            start_backward = 1'b0;
            cycles++;
            if (cycles == 3 && !seen) begin
                bank_sel       = bank_e'((vec_bank[t] == 2'd2) ? 2'd0 : vec_bank[t] + 2'd1);
                words_num      = ADDR_WIDTH'(vec_words[t] + 3);
                start_forward  = backward;
                start_backward = !backward;
            end
        end
        checker_i.end_transfer();
        repeat (4) @(posedge core_clk);  // idle gap where a stray strobe shows.
        #5;
    endtask

    // glb contents first, then dram delays and words, all from one stream.
    initial begin
        logic [31:0] hi;
        logic [31:0] lo;
        int          delay;
        seed = SEED;
        for (int i = 0; i < GLB_WORDS; i++) begin
            hi         = $random(seed);
            lo         = $random(seed);
            glb_mem[i] = {hi, lo};
        end
        forever begin
            @(posedge link_clk);
            if (dram_r_en === 1'b1) begin
                delay = 1 + ($unsigned($random(seed)) % 3);
                repeat (delay - 1) @(posedge link_clk);
                hi = $random(seed);
                lo = $random(seed);
                #5;
                dram_valid = 1'b1;
                dram_rdata = {hi, lo};
                checker_i.expect_glb_write({hi, lo});
                @(posedge link_clk);
                #5;
                dram_valid = 1'b0;
            end
        end
    end

    always @(posedge core_clk) begin
        if (glb_rd.en === 1'b1) begin
            rd_addr = glb_rd.addr;
            #5;
            if (int'(rd_addr) < GLB_WORDS) begin
                glb_rdata = glb_mem[int'(rd_addr)];
            end else begin
                glb_rdata = '0;
            end
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_ns);
        abort_run($sformatf("timeout after %0d ns, a transfer never finished", limit_ns));
    end

    initial begin
        longint sum;
        arst_n         = 1'b0;
        start_forward  = 1'b0;
        start_backward = 1'b0;
        bank_sel       = BANK_IFMAP;
        words_num      = '0;
        sum            = 0;
        read_vectors();
        if (num_tests == 0) begin
            abort_run($sformatf("no transfers read from %s", VECTOR_FILE));
        end else begin
            for (int t = 0; t < num_tests; t++) begin
                sum += longint'(vec_words[t]);
            end
            limit_ns = sum * longint'(10 * LINK_PERIOD) + longint'(num_tests) * 64'd2000
                       + longint'(20 * CORE_PERIOD);
            limit_ready = 1'b1;
            repeat (2) @(posedge core_clk);
            #5;
            arst_n = 1'b1;
            repeat (5) @(posedge core_clk);  // internal reset syncs release.
            #5;
            for (int t = 0; t < num_tests; t++) begin
                run_transfer(t);
            end
            $display("tests %0d, failed %0d, errors %0d", checker_i.tests, checker_i.failed,
                     checker_i.errors);
            if (checker_i.errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- interface_unit.f
hw/iface_pkg.sv
hw/cdc_fifo.sv
hw/glb_bank_port.sv
hw/link_dma.sv
hw/transfer_ctrl.sv
hw/interface_unit.sv
tests/interface_checker.sv
tests/tb_interface_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_interface_unit
FLAGS     ?= --binary --timing
FILELIST  ?= interface_unit.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/interface_vectors.txt
# columns: direction bank words
# direction 0 moves dram to glb, 1 moves glb to dram; bank 0 ifmap, 1 filter, 2 bias
0 0 4
0 1 7
0 2 5
1 0 6
1 1 9
1 2 3
0 0 40
1 1 24
0 2 1
1 0 1
0 1 33
1 2 17
0 0 18
1 0 12
